/* cpu_ex_mem_slice.f */
logic/cpu_pkg.sv
logic/ex_mem_if.sv
logic/ex_alu.sv
logic/store_data_fwd.sv
logic/pipe_stage_reg.sv
logic/data_mem.sv
logic/cpu_ex_mem_slice.sv
sim/tb_clk_gen.sv
sim/tb_cpu_ex_mem_slice.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cpu_ex_mem_slice
FILELIST   := cpu_ex_mem_slice.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -F -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_cpu_ex_mem_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_ex_mem_slice;

  localparam int  mem_depth = 256;       // Data memory words in the DUT
  localparam real period_ns = 40.0;

  // Control bits per row as {mem_enable, mem_write, reg_write, mem_to_reg, hlt, pcs}
  localparam logic [5:0] ctl_alu   = 6'b00_1000;
  localparam logic [5:0] ctl_store = 6'b11_0000;
  localparam logic [5:0] ctl_load  = 6'b10_1100;
  localparam logic [5:0] ctl_none  = 6'b00_0000;

  typedef struct packed {
    logic                         stall;
    logic [cpu_pkg::data_w-1:0]   pc;
    logic [cpu_pkg::data_w-1:0]   a;
    logic [cpu_pkg::data_w-1:0]   b;
    cpu_pkg::alu_op_e             op;
    logic [cpu_pkg::reg_id_w-1:0] src2;
    logic [cpu_pkg::data_w-1:0]   sdata;
    cpu_pkg::mem_ctrl_t           mc;
    cpu_pkg::wb_ctrl_t            wc;
    logic [cpu_pkg::flag_w-1:0]   x_flags;  // Same-cycle flags
    cpu_pkg::mem_wb_t             x_wb;     // What this row leaves on the wb outputs
  } row_t;

  logic                         clk;
  logic                         arst_n;
  logic                         stall;
  logic [cpu_pkg::data_w-1:0]   pc_next, operand_a, operand_b, store_data;
  cpu_pkg::alu_op_e             alu_op;
  logic [cpu_pkg::reg_id_w-1:0] src_reg2, reg_rd, wb_reg_rd;
  logic                         mem_enable, mem_write, reg_write, mem_to_reg, hlt, pcs;
  logic [cpu_pkg::flag_w-1:0]   flags;
  logic [cpu_pkg::data_w-1:0]   wb_pc_next, wb_data;
  logic                         wb_reg_write, wb_hlt, wb_pcs;

  row_t        rows[$];                  // Stimulus table, the model fills the expected fields
  int          seed        = 88012;
  int          value_errs  = 0;
  int          other_errs  = 0;
  logic [15:0] pc_cnt      = 16'h0100;   // pc_next of the next row added
  logic        table_ready = 1'b0;

  tb_clk_gen #(.period_ns(period_ns), .rst_cycles(8)) clk_gen_i (.clk(clk), .arst_n(arst_n));

  cpu_ex_mem_slice #(.DATA_MEM_DEPTH(mem_depth)) cpu_ex_mem_slice_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] rand16();
    return 16'($random(seed));
  endfunction

  task automatic add_row(input logic stl, input cpu_pkg::alu_op_e op,
                         input logic [15:0] a, input logic [15:0] b,
                         input logic [3:0] rd, input logic [3:0] src2,
                         input logic [15:0] sdata, input logic [5:0] ctl);
    row_t r;
    r       = '0;
    r.stall = stl;
    r.pc    = pc_cnt;
    r.op    = op;
    r.a     = a;
    r.b     = b;
    r.src2  = src2;
    r.sdata = sdata;
    r.mc    = ctl[5:4];
    r.wc    = {rd, ctl[3:0]};
    pc_cnt  = pc_cnt + 16'd2;            // Every row gets its own pc_next
    rows.push_back(r);
  endtask

  task automatic build_table();
    for (int k = 0; k < 8; k++) begin    // Each ALU operation with random operands
      add_row(1'b0, cpu_pkg::alu_op_e'(3'(k)), rand16(), rand16(), 4'(k + 1), 4'd0,
              16'h0, ctl_alu);
    end
    add_row(1'b0, cpu_pkg::alu_add, 16'h7fff, 16'h0001, 4'd1, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_add, 16'h8000, 16'h8000, 4'd2, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_sub, 16'h8000, 16'h0001, 4'd3, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_sub, 16'h1234, 16'h1234, 4'd4, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_sra, 16'h8010, 16'hfff4, 4'd1, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_sll, 16'h00ff, 16'h0018, 4'd2, 4'd0, 16'h0, ctl_alu);
    // Plain store then load of the same word
    add_row(1'b0, cpu_pkg::alu_add, 16'h0040, 16'h0, 4'd0, 4'd12, 16'hbeef, ctl_store);
    add_row(1'b0, cpu_pkg::alu_add, 16'h0040, 16'h0, 4'd9, 4'd0, 16'h0, ctl_load);
    // Store source written by the row just ahead
    add_row(1'b0, cpu_pkg::alu_add, 16'h1000, 16'h0234, 4'd5, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_xor, 16'h5a5a, 16'h0ff0, 4'd6, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_add, 16'h0050, 16'h0, 4'd0, 4'd6, 16'hdead, ctl_store);
    // Store source written two rows ahead
    add_row(1'b0, cpu_pkg::alu_or, 16'h0f00, 16'h00a5, 4'd7, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_and, 16'hffff, 16'h3c3c, 4'd8, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_add, 16'h0052, 16'h0, 4'd0, 4'd7, 16'hdead, ctl_store);
    // Both stages target r10, the nearer one must win
    add_row(1'b0, cpu_pkg::alu_add, 16'h0001, 16'h0001, 4'd10, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_add, 16'h0100, 16'h0100, 4'd10, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_add, 16'h0054, 16'h0, 4'd0, 4'd10, 16'hdead, ctl_store);
    // A load just ahead has no value yet
    add_row(1'b0, cpu_pkg::alu_add, 16'h0040, 16'h0, 4'd11, 4'd0, 16'h0, ctl_load);
    add_row(1'b0, cpu_pkg::alu_add, 16'h0056, 16'h0, 4'd0, 4'd11, 16'h1111, ctl_store);
    // Register 0 never forwards
    add_row(1'b0, cpu_pkg::alu_add, 16'h7777, 16'h0, 4'd0, 4'd0, 16'h0, ctl_alu);
    add_row(1'b0, cpu_pkg::alu_add, 16'h0058, 16'h0, 4'd0, 4'd0, 16'h0bad, ctl_store);
    for (int k = 0; k < 5; k++) begin    // Read back every forwarded store
      add_row(1'b0, cpu_pkg::alu_add, 16'(16'h0050 + 2 * k), 16'h0, 4'(k + 1), 4'd0,
              16'h0, ctl_load);
    end
    // Store parked in EX/MEM while the pipe is held
    add_row(1'b0, cpu_pkg::alu_add, 16'h0060, 16'h0, 4'd0, 4'd12, 16'hcafe, ctl_store);
    repeat (3) begin
      add_row(1'b1, cpu_pkg::alu_op_e'(3'(rand16())), rand16(), rand16(), 4'd0, 4'd0,
              16'h0, ctl_none);
    end
    add_row(1'b0, cpu_pkg::alu_add, 16'h0060, 16'h0, 4'd6, 4'd0, 16'h0, ctl_load);
    add_row(1'b0, cpu_pkg::alu_add, rand16(), rand16(), 4'd0, 4'd0, 16'h0, 6'b00_0010);
    add_row(1'b0, cpu_pkg::alu_sub, rand16(), rand16(), 4'd0, 4'd0, 16'h0, 6'b00_0001);
    add_row(1'b0, cpu_pkg::alu_add, rand16(), rand16(), 4'd0, 4'd0, 16'h0, 6'b00_0011);
    repeat (2) add_row(1'b0, cpu_pkg::alu_add, 16'h0, 16'h0, 4'd0, 4'd0, 16'h0, ctl_none);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  task automatic alu_model(input row_t r, output logic [15:0] res, output logic [2:0] flg);
    int          wide;                   // Exact signed sum or difference
    logic        v;
    logic [31:0] ext;                    // Sign-extended a for the arithmetic shift
    wide = 0;
    ext  = {{16{r.a[15]}}, r.a};
    case (r.op)
      cpu_pkg::alu_add: wide = int'($signed(r.a)) + int'($signed(r.b));
      cpu_pkg::alu_sub: wide = int'($signed(r.a)) - int'($signed(r.b));
      default:          wide = 0;
    endcase
    case (r.op)
      cpu_pkg::alu_and: res = r.a & r.b;
      cpu_pkg::alu_or:  res = r.a | r.b;
      cpu_pkg::alu_xor: res = r.a ^ r.b;
      cpu_pkg::alu_sll: res = r.a << r.b[3:0];
      cpu_pkg::alu_srl: res = r.a >> r.b[3:0];
      cpu_pkg::alu_sra: res = 16'(ext >> r.b[3:0]);
      default:          res = 16'(wide);
    endcase
    v   = (wide > 32767) || (wide < -32768);  // Out of the 16-bit signed range
    flg = {res == '0, v, res[15]};
  endtask

  task automatic run_model();
    logic [15:0] mem_m [int];            // Only stored words exist
    int          ex_idx;                 // Row held in EX/MEM, -1 for reset contents
    int          wb_idx;                 // Row held in MEM/WB
    logic [15:0] ex_alu;
    logic [15:0] ex_store;
    logic [15:0] wb_val;
    logic [15:0] res;
    logic [2:0]  flg;
    logic [15:0] fwd;
    int          addr;
    row_t        r;
    row_t        e;
    ex_idx   = -1;
    wb_idx   = -1;
    ex_alu   = '0;
    ex_store = '0;
    wb_val   = '0;
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      alu_model(r, res, flg);
      r.x_flags = flg;
      rows[i]   = r;
      if (!r.stall) begin                // A stalled edge moves nothing
        fwd = r.sdata;
        if ((r.src2 != '0) && (wb_idx >= 0)) begin
          e = rows[wb_idx];
          if (e.wc.reg_write && (e.wc.reg_rd == r.src2)) fwd = wb_val;
        end
        if ((r.src2 != '0) && (ex_idx >= 0)) begin  // Checked last so it takes priority
          e = rows[ex_idx];
          if (e.wc.reg_write && !e.wc.mem_to_reg && (e.wc.reg_rd == r.src2)) fwd = ex_alu;
        end
        wb_val = '0;
        if (ex_idx >= 0) begin
          e      = rows[ex_idx];
          addr   = int'(ex_alu) % mem_depth;
          wb_val = ex_alu;
          if (e.wc.mem_to_reg) begin
            assert (mem_m.exists(addr)) else begin
              other_errs++;
              $display("Row %0d loads word %0d that was never stored", ex_idx, addr);
            end
            wb_val = mem_m[addr];
          end
          if (e.mc.mem_enable && e.mc.mem_write) mem_m[addr] = ex_store;
          e.x_wb       = {e.pc, wb_val, e.wc};
          rows[ex_idx] = e;
        end
        wb_idx   = ex_idx;
        ex_idx   = i;
        ex_alu   = res;
        ex_store = fwd;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////////////////////
  task automatic apply_row(input row_t r);
    stall      = r.stall;
    pc_next    = r.pc;
    operand_a  = r.a;
    operand_b  = r.b;
    alu_op     = r.op;
    src_reg2   = r.src2;
    store_data = r.sdata;
    mem_enable = r.mc.mem_enable;
    mem_write  = r.mc.mem_write;
    reg_rd     = r.wc.reg_rd;
    reg_write  = r.wc.reg_write;
    mem_to_reg = r.wc.mem_to_reg;
    hlt        = r.wc.hlt;
    pcs        = r.wc.pcs;
  endtask

  task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      value_errs++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_wb(input int idx);
    cpu_pkg::mem_wb_t x;
    x = '0;                              // Reset contents until a row gets through
    if (idx >= 0) x = rows[idx].x_wb;
    check_val("wb_pc_next", x.pc_next, wb_pc_next);
    check_val("wb_data", x.wb_data, wb_data);
    check_val("wb_reg_rd", 16'(x.wb_ctrl.reg_rd), 16'(wb_reg_rd));
    check_val("wb_reg_write", 16'(x.wb_ctrl.reg_write), 16'(wb_reg_write));
    check_val("wb_hlt", 16'(x.wb_ctrl.hlt), 16'(wb_hlt));
    check_val("wb_pcs", 16'(x.wb_ctrl.pcs), 16'(wb_pcs));
  endtask

  initial begin
    int ex_idx;                          // Row that sits in EX/MEM after the coming edge
    int wb_idx;                          // Row that the wb outputs show now
    ex_idx = -1;
    wb_idx = -1;
    apply_row('0);
    build_table();
    run_model();
    table_ready = 1'b1;
    wait (arst_n === 1'b1);
    check_wb(-1);                        // MEM/WB reset contents before any clock edge
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clk);
      check_wb(wb_idx);                  // Outputs settled since the last rising edge
      apply_row(rows[i]);
      #1;
      check_val("flags", 16'(rows[i].x_flags), 16'(flags));
      if (!rows[i].stall) begin
        wb_idx = ex_idx;
        ex_idx = i;
      end
    end
    @(negedge clk);
    check_wb(wb_idx);
    $display("Errors %0d wrong values, %0d other", value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // One clock per row plus room for reset and the pipeline drain
  initial begin
    wait (table_ready);
    #((rows.size() + 20) * period_ns);
    $display("Watchdog ran out of time before the last row was checked");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real period_ns  = 40.0,      // Clock period
  parameter int  rst_cycles = 8          // Rising edges seen with reset held
) (
  output logic clk,
  output logic arst_n                    // Async reset, active low
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // Release on a falling edge so no flop sees reset and clock move together
  initial begin
    arst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* logic/cpu_ex_mem_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_ex_mem_slice #(
  parameter int DATA_MEM_DEPTH = 256     // Data memory words
) (
  input  logic                          clk,
  input  logic                          arst_n,        // Async reset, active low
  input  logic                          stall,         // Holds both stage registers
  // Execute operands and control from decode
  input  logic [cpu_pkg::data_w-1:0]    pc_next,
  input  logic [cpu_pkg::data_w-1:0]    operand_a,
  input  logic [cpu_pkg::data_w-1:0]    operand_b,
  input  cpu_pkg::alu_op_e              alu_op,
  input  logic [cpu_pkg::reg_id_w-1:0]  src_reg2,
  input  logic [cpu_pkg::data_w-1:0]    store_data,    // Register file value for stores
  input  logic                          mem_enable,
  input  logic                          mem_write,
  input  logic [cpu_pkg::reg_id_w-1:0]  reg_rd,
  input  logic                          reg_write,
  input  logic                          mem_to_reg,
  input  logic                          hlt,
  input  logic                          pcs,
  // Execute flags, same cycle
  output logic [cpu_pkg::flag_w-1:0]    flags,
  // Write-back stage
  output logic [cpu_pkg::data_w-1:0]    wb_pc_next,
  output logic [cpu_pkg::data_w-1:0]    wb_data,
  output logic [cpu_pkg::reg_id_w-1:0]  wb_reg_rd,
  output logic                          wb_reg_write,
  output logic                          wb_hlt,
  output logic                          wb_pcs
);

  logic [cpu_pkg::data_w-1:0]   alu_result;  // Execute result
  logic [cpu_pkg::data_w-1:0]   fwd_store;   // Store word after forwarding
  cpu_pkg::ex_mem_t             ex_mem_d;    // EX/MEM next contents
  cpu_pkg::mem_wb_t             mem_wb_d;    // MEM/WB next contents
  cpu_pkg::mem_wb_t             mem_wb_q;    // MEM/WB registered

  ex_mem_if ex_mem_bus ();                   // Registered EX/MEM bundle

  ////////////////////////////////////////////////////////////////////////////
  // Execute stage
  ////////////////////////////////////////////////////////////////////////////
  ex_alu ex_alu_i (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (operand_a),
    .b      (operand_b),
    .op     (alu_op),
    .result (alu_result),
    .flags  (flags)
  );

  store_data_fwd store_data_fwd_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .src_reg2   (src_reg2),
    .store_data (store_data),
    .ex_mem     (ex_mem_bus.fwd_src),
    .mem_wb     (mem_wb_q),
    .fwd_data   (fwd_store)
  );

  // Pack the EX/MEM bundle
  assign ex_mem_d.pc_next             = pc_next;
  assign ex_mem_d.alu_out             = alu_result;
  assign ex_mem_d.store_data          = fwd_store;
  assign ex_mem_d.src_reg2            = src_reg2;
  assign ex_mem_d.mem_ctrl.mem_enable = mem_enable;
  assign ex_mem_d.mem_ctrl.mem_write  = mem_write;
  assign ex_mem_d.wb_ctrl.reg_rd      = reg_rd;
  assign ex_mem_d.wb_ctrl.reg_write   = reg_write;
  assign ex_mem_d.wb_ctrl.mem_to_reg  = mem_to_reg;
  assign ex_mem_d.wb_ctrl.hlt         = hlt;
  assign ex_mem_d.wb_ctrl.pcs         = pcs;

  pipe_stage_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem_reg_i (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .d      (ex_mem_d),
    .q      (ex_mem_bus.bundle)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory stage
  ////////////////////////////////////////////////////////////////////////////
  data_mem #(.DATA_MEM_DEPTH(DATA_MEM_DEPTH)) data_mem_i (
    .clk      (clk),
    .stall    (stall),
    .ex_mem   (ex_mem_bus.consumer),
    .mem_wb_d (mem_wb_d)
  );

  pipe_stage_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb_reg_i (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .d      (mem_wb_d),
    .q      (mem_wb_q)
  );

  // Write-back outputs straight from the MEM/WB register
  assign wb_pc_next   = mem_wb_q.pc_next;
  assign wb_data      = mem_wb_q.wb_data;
  assign wb_reg_rd    = mem_wb_q.wb_ctrl.reg_rd;
  assign wb_reg_write = mem_wb_q.wb_ctrl.reg_write;
  assign wb_hlt       = mem_wb_q.wb_ctrl.hlt;
  assign wb_pcs       = mem_wb_q.wb_ctrl.pcs;

endmodule

`default_nettype wire

/* logic/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
  parameter int DATA_MEM_DEPTH = 256     // Words, power of two
) (
  input  logic             clk,
  input  logic             stall,        // Blocks writes while the pipe is held
  ex_mem_if.consumer       ex_mem,       // Registered EX/MEM bundle
  output cpu_pkg::mem_wb_t mem_wb_d      // Next MEM/WB contents
);

  localparam int addr_w = $clog2(DATA_MEM_DEPTH);

  // Size check at elaboration
  if ((DATA_MEM_DEPTH < 2) || (DATA_MEM_DEPTH > 65536)
      || ((DATA_MEM_DEPTH & (DATA_MEM_DEPTH - 1)) != 0)) begin : g_depth_bad
    $error("DATA_MEM_DEPTH must be a power of two from 2 to 65536");
  end

  logic [cpu_pkg::data_w-1:0] mem [DATA_MEM_DEPTH];  // Storage array, no reset
  logic [addr_w-1:0]          addr;                  // Word address
  logic [cpu_pkg::data_w-1:0] rd_word;               // Word at addr this cycle
  logic                       wr_en;                 // Store commits this edge

  // Low address bits give the wrap at the array size
  assign addr  = ex_mem.bundle.alu_out[addr_w-1:0];
  assign wr_en = ex_mem.bundle.mem_ctrl.mem_enable
              && ex_mem.bundle.mem_ctrl.mem_write
              && !stall;

  //////////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= ex_mem.bundle.store_data;
    end
  end

  assign rd_word = mem[addr];            // Asynchronous read

  //////////////////////////////////////////////////////////////////////////
  // MEM/WB bundle
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    mem_wb_d.pc_next = ex_mem.bundle.pc_next;
    mem_wb_d.wb_ctrl = ex_mem.bundle.wb_ctrl;   // Write-back control rides through
    if (ex_mem.bundle.wb_ctrl.mem_to_reg) begin
      mem_wb_d.wb_data = rd_word;               // Load result
    end else begin
      mem_wb_d.wb_data = ex_mem.bundle.alu_out;
    end
  end

  // Decode never asks for a store with the memory disabled
  write_needs_enable_a: assert property (@(posedge clk)
    ex_mem.bundle.mem_ctrl.mem_write |-> ex_mem.bundle.mem_ctrl.mem_enable)
    else $error("data_mem mem_write without mem_enable");

endmodule

`default_nettype wire

/* logic/pipe_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg #(
  parameter type payload_t = logic [15:0]  // Bundle carried across the stage boundary
) (
  input  logic     clk,
  input  logic     arst_n,               // Async reset, active low
  input  logic     stall,                // Hold the current contents
  input  payload_t d,                    // Bundle from the earlier stage
  output payload_t q                     // Bundle seen by the later stage
);

  //////////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////////
  // All zeros after reset leaves every strobe in the bundle inactive
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;                            // Advance when the pipe is not held
    end
  end

  // A stalled edge must not move anything into the later stage
  hold_on_stall_a: assert property (@(posedge clk) disable iff (!arst_n)
    stall |=> $stable(q))
    else $error("pipe_stage_reg changed while stalled");

endmodule

`default_nettype wire

/* logic/store_data_fwd.sv */
`timescale 1ns/1ps
`default_nettype none

module store_data_fwd (
  input  logic                          clk,        // Only used to sample the check
  input  logic                          arst_n,     // Async reset, active low
  input  logic [cpu_pkg::reg_id_w-1:0]  src_reg2,   // Register holding the store word
  input  logic [cpu_pkg::data_w-1:0]    store_data, // Register file value from decode
  ex_mem_if.fwd_src                     ex_mem,     // Instruction one ahead
  input  cpu_pkg::mem_wb_t              mem_wb,     // Instruction two ahead
  output logic [cpu_pkg::data_w-1:0]    fwd_data    // Freshest store word
);

  logic src_live;                        // Register 0 never carries a produced value
  logic hit_ex_mem;                      // ALU result one ahead targets our source
  logic hit_mem_wb;                      // Write-back value two ahead targets our source

  assign src_live = (src_reg2 != '0);

  // A load one ahead has no data yet so only ALU results qualify here
  assign hit_ex_mem = src_live
                   && ex_mem.bundle.wb_ctrl.reg_write
                   && !ex_mem.bundle.wb_ctrl.mem_to_reg
                   && (ex_mem.bundle.wb_ctrl.reg_rd == src_reg2);

  assign hit_mem_wb = src_live
                   && mem_wb.wb_ctrl.reg_write
                   && (mem_wb.wb_ctrl.reg_rd == src_reg2);

  // Nearer instruction wins
  always_comb begin
    if (hit_ex_mem)      fwd_data = ex_mem.bundle.alu_out;
    else if (hit_mem_wb) fwd_data = mem_wb.wb_data;
    else                 fwd_data = store_data;
  end

  // Stores through register 0 must see the decode value whatever sits downstream
  zero_reg_no_fwd_a: assert property (@(posedge clk) disable iff (!arst_n)
    (src_reg2 == '0) |-> (fwd_data == store_data))
    else $error("store_data_fwd forwarded into register 0");

endmodule

`default_nettype wire

/* logic/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  logic                           clk,     // Only used to sample the op check
  input  logic                           arst_n,  // Async reset, active low
  input  logic [cpu_pkg::data_w-1:0]     a,       // First operand
  input  logic [cpu_pkg::data_w-1:0]     b,       // Second operand, low bits give shift amount
  input  cpu_pkg::alu_op_e               op,      // Operation select
  output logic [cpu_pkg::data_w-1:0]     result,  // Operation result
  output logic [cpu_pkg::flag_w-1:0]     flags    // Z, V and N
);

  localparam int msb = cpu_pkg::data_w - 1;

  logic [cpu_pkg::data_w-1:0] res;       // Combinational result
  logic                       ovf;       // Signed overflow, add and subtract only
  logic [3:0]                 shamt;     // Shift amount

  assign shamt = b[3:0];

  //////////////////////////////////////////////////////////////////////////
  // Operation decode
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    res = '0;
    ovf = 1'b0;
    case (op)
      cpu_pkg::alu_add: begin
        res = a + b;
        ovf = (a[msb] == b[msb]) && (res[msb] != a[msb]);  // Like signs give an unlike sum
      end
      cpu_pkg::alu_sub: begin
        res = a - b;
        ovf = (a[msb] != b[msb]) && (res[msb] != a[msb]);  // Unlike signs flip the minuend sign
      end
      cpu_pkg::alu_and: res = a & b;
      cpu_pkg::alu_or:  res = a | b;
      cpu_pkg::alu_xor: res = a ^ b;
      cpu_pkg::alu_sll: res = a << shamt;
      cpu_pkg::alu_srl: res = a >> shamt;
      cpu_pkg::alu_sra: res = $signed(a) >>> shamt;        // Sign bit fills from the left
      default:          res = '0;
    endcase
  end

  assign result = res;

  // Flags follow the same-cycle operands
  assign flags[cpu_pkg::flag_z] = (res == '0);
  assign flags[cpu_pkg::flag_v] = ovf;
  assign flags[cpu_pkg::flag_n] = res[msb];

  // Decode must always present a real opcode once out of reset
  op_known_a: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(op))
    else $error("ex_alu op is unknown");

endmodule

`default_nettype wire

/* logic/ex_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Carries the registered EX/MEM bundle from the pipeline register to the
// memory stage and back to the execute-stage store forwarding
interface ex_mem_if;

  cpu_pkg::ex_mem_t bundle;              // Whole EX/MEM payload as one packed word

  // The EX/MEM register drives the bundle
  modport producer (
    output bundle
  );

  // Memory stage reads address, store word and control
  modport consumer (
    input bundle
  );

  // Forwarding looks at wb_ctrl and alu_out only
  modport fwd_src (
    input bundle
  );

endinterface

`default_nettype wire

/* logic/cpu_pkg.sv */
package cpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int data_w   = 16;          // Data word and byte-free address width
  localparam int reg_id_w = 4;           // Register ID width, register 0 reads as zero

  // Bit positions inside the ALU flag vector
  localparam int flag_w = 3;
  localparam int flag_z = 2;             // Result is zero
  localparam int flag_v = 1;             // Signed overflow on add or subtract
  localparam int flag_n = 0;             // Result MSB

  ////////////////////////////////////////////////////////////////////////////
  // ALU operation encoding
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_sll = 3'd5,
    alu_srl = 3'd6,
    alu_sra = 3'd7
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline bundles
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic mem_enable;                    // Data memory access in this instruction
    logic mem_write;                     // Store when set, load otherwise
  } mem_ctrl_t;

  // Same bit order as the old WB signal vector {reg_rd, RegWrite, MemtoReg, HLT, PCS}
  typedef struct packed {
    logic [reg_id_w-1:0] reg_rd;         // Destination register
    logic                reg_write;      // Write the register file in WB
    logic                mem_to_reg;     // WB value comes from memory
    logic                hlt;            // Halt instruction
    logic                pcs;            // PC save instruction
  } wb_ctrl_t;

  typedef struct packed {
    logic [data_w-1:0]   pc_next;        // Address of the following instruction
    logic [data_w-1:0]   alu_out;        // Execute result, also the memory address
    logic [data_w-1:0]   store_data;     // Word to store after forwarding
    logic [reg_id_w-1:0] src_reg2;       // Second source register of the instruction
    mem_ctrl_t           mem_ctrl;
    wb_ctrl_t            wb_ctrl;
  } ex_mem_t;

  typedef struct packed {
    logic [data_w-1:0] pc_next;
    logic [data_w-1:0] wb_data;          // Loaded word or ALU result
    wb_ctrl_t          wb_ctrl;
  } mem_wb_t;

endpackage
